/* rtl/boot_loader_top.sv */
`timescale 1ns/1ps

module boot_loader_top #(
  parameter int RX_DEPTH   = 8,
  parameter int OUT_DEPTH  = 16,
  parameter int TX_CREDITS = 4
) (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 enable,
  input  loader_pkg::byte_t    rx_byte,
  input  logic                 rx_valid,
  output logic                 rx_credit,
  output loader_pkg::mem_wr_t  dmem_wr,
  output loader_pkg::mem_wr_t  imem_wr,
  output loader_pkg::word_t    first_pc,
  output loader_pkg::word_t    program_size,
  output logic                 program_fin,
  input  loader_pkg::out_req_t out_req,
  input  logic                 out_valid,
  output logic                 out_stall,
  output loader_pkg::byte_t    tx_byte,
  output logic                 tx_valid,
  input  logic                 tx_credit
);

  // assembled words toward the control FSM
  loader_pkg::word_t word;
  logic              word_valid;
  logic              word_ready;

  word_assembler #(
    .RX_DEPTH (RX_DEPTH)
  ) word_assembler_i (
    .clk        (clk),
    .rstn       (rstn),
    .rx_byte    (rx_byte),
    .rx_valid   (rx_valid),
    .word_ready (word_ready),
    .rx_credit  (rx_credit),
    .word       (word),
    .word_valid (word_valid)
  );

  loader_ctrl loader_ctrl_i (
    .clk          (clk),
    .rstn         (rstn),
    .enable       (enable),
    .word         (word),
    .word_valid   (word_valid),
    .word_ready   (word_ready),
    .dmem_wr      (dmem_wr),
    .imem_wr      (imem_wr),
    .first_pc     (first_pc),
    .program_size (program_size),
    .program_fin  (program_fin)
  );

  // output path is independent of the loader
  word_serializer #(
    .OUT_DEPTH  (OUT_DEPTH),
    .TX_CREDITS (TX_CREDITS)
  ) word_serializer_i (
    .clk       (clk),
    .rstn      (rstn),
    .out_req   (out_req),
    .out_valid (out_valid),
    .tx_credit (tx_credit),
    .out_stall (out_stall),
    .tx_byte   (tx_byte),
    .tx_valid  (tx_valid)
  );

endmodule

/* rtl/loader_ctrl.sv */
`timescale 1ns/1ps

module loader_ctrl (
  input  logic                clk,
  input  logic                rstn,
  input  logic                enable,
  input  loader_pkg::word_t   word,
  input  logic                word_valid,
  output logic                word_ready,
  output loader_pkg::mem_wr_t dmem_wr,
  output loader_pkg::mem_wr_t imem_wr,
  output loader_pkg::word_t   first_pc,
  output loader_pkg::word_t   program_size,
  output logic                program_fin
);

  typedef enum logic [2:0] {
    ST_TOTAL,
    ST_DCOUNT,
    ST_PC,
    ST_DATA,
    ST_PROG,
    ST_FIN
  } state_t;

  state_t            state;
  // words still to come in each section
  loader_pkg::word_t data_left;
  loader_pkg::word_t prog_left;
  // next byte address per memory
  loader_pkg::word_t dmem_addr;
  loader_pkg::word_t imem_addr;
  // write payload shared by both memory ports
  loader_pkg::word_t wr_addr;
  loader_pkg::word_t wr_data;
  logic              dmem_en;
  logic              imem_en;
  logic              accept;
  loader_pkg::word_t prog_words;

  // stalled when disabled or done
  assign word_ready = enable && (state != ST_FIN);
  assign accept     = word_valid && word_ready;

  // prog_left holds total/4 here, word is D
  assign prog_words = prog_left - loader_pkg::HDR_WORDS - word;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state        <= ST_TOTAL;
      data_left    <= '0;
      prog_left    <= '0;
      dmem_addr    <= '0;
      imem_addr    <= '0;
      dmem_en      <= 1'b0;
      imem_en      <= 1'b0;
      first_pc     <= '0;
      program_size <= '0;
      program_fin  <= 1'b0;
    end else begin
      dmem_en     <= 1'b0;
      imem_en     <= 1'b0;
      // one cycle behind the last write
      program_fin <= (state == ST_FIN);
      if (accept) begin
        case (state)
          ST_TOTAL: begin
            prog_left <= word / loader_pkg::WORD_BYTES;
            state     <= ST_DCOUNT;
          end
          ST_DCOUNT: begin
            data_left    <= word;
            prog_left    <= prog_words;
            program_size <= prog_words;
            state        <= ST_PC;
          end
          ST_PC: begin
            first_pc <= word;
            // empty sections are skipped
            if (data_left != '0) begin
              state <= ST_DATA;
            end else if (prog_left != '0) begin
              state <= ST_PROG;
            end else begin
              state <= ST_FIN;
            end
          end
          ST_DATA: begin
            dmem_en   <= 1'b1;
            dmem_addr <= dmem_addr + loader_pkg::WORD_BYTES;
            data_left <= data_left - 1'b1;
            if (data_left == 32'd1) begin
              state <= (prog_left != '0) ? ST_PROG : ST_FIN;
            end
          end
          ST_PROG: begin
            imem_en   <= 1'b1;
            imem_addr <= imem_addr + loader_pkg::WORD_BYTES;
            prog_left <= prog_left - 1'b1;
            if (prog_left == 32'd1) begin
              state <= ST_FIN;
            end
          end
          default: begin
            state <= ST_FIN;
          end
        endcase
      end
    end
  end

  // address is taken before the counter steps
  always_ff @(posedge clk) begin
    if (accept) begin
      wr_data <= word;
      wr_addr <= (state == ST_PROG) ? imem_addr : dmem_addr;
    end
  end

  assign dmem_wr = '{en: dmem_en, addr: wr_addr, data: wr_data};
  assign imem_wr = '{en: imem_en, addr: wr_addr, data: wr_data};

endmodule

/* rtl/loader_pkg.sv */
package loader_pkg;

  // one byte on either byte stream
  typedef logic [7:0] byte_t;

  // machine word as the core sees it
  typedef logic [31:0] word_t;

  // header words: total size in bytes, data word count, first pc
  localparam int unsigned HDR_WORDS = 3;

  // bytes per word
  // also the address step for both memories
  localparam int unsigned WORD_BYTES = 4;

  // one memory write
  // en is a single-cycle pulse, addr is a byte address
  typedef struct packed {
    logic  en;
    word_t addr;
    word_t data;
  } mem_wr_t;

  // one request from the core to the output path
  // byte_mode set: only data[7:0] goes out
  // byte_mode clear: all four bytes, lsb first
  typedef struct packed {
    logic  byte_mode;
    word_t data;
  } out_req_t;

endpackage

/* rtl/word_assembler.sv */
`timescale 1ns/1ps

module word_assembler #(
  parameter int RX_DEPTH = 8
) (
  input  logic              clk,
  input  logic              rstn,
  input  loader_pkg::byte_t rx_byte,
  input  logic              rx_valid,
  input  logic              word_ready,
  output logic              rx_credit,
  output loader_pkg::word_t word,
  output logic              word_valid
);

  localparam int PTR_W = (RX_DEPTH > 1) ? $clog2(RX_DEPTH) : 1;
  localparam int CNT_W = $clog2(RX_DEPTH + 1);

  // circular byte buffer, sized to the source's credits
  loader_pkg::byte_t buf_mem [RX_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  fill;
  // next byte slot in the word, 0 is the msb
  logic [1:0]        byte_pos;
  logic              pop;

  // take a byte while the holding word is empty or leaving
  assign pop = (fill != '0) && (!word_valid || word_ready);

  // byte storage
  always_ff @(posedge clk) begin
    if (rx_valid) begin
      buf_mem[wr_ptr] <= rx_byte;
    end
  end

  // pointers and fill level
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      // source never sends without credit, so no overflow check
      if (rx_valid) begin
        wr_ptr <= (wr_ptr == PTR_W'(RX_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(RX_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({rx_valid, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
    end
  end

  // credit pulse per popped byte, word completion
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rx_credit  <= 1'b0;
      byte_pos   <= 2'd0;
      word_valid <= 1'b0;
    end else begin
      rx_credit <= pop;
      if (pop) begin
        byte_pos <= byte_pos + 2'd1;
      end
      // fourth byte completes the word
      if (pop && (byte_pos == 2'd3)) begin
        word_valid <= 1'b1;
      end else if (word_ready) begin
        word_valid <= 1'b0;
      end
    end
  end

  // shift register is also the holding register, msb first
  always_ff @(posedge clk) begin
    if (pop) begin
      word <= {word[23:0], buf_mem[rd_ptr]};
    end
  end

endmodule

/* rtl/word_serializer.sv */
`timescale 1ns/1ps

module word_serializer #(
  parameter int OUT_DEPTH  = 16,
  parameter int TX_CREDITS = 4
) (
  input  logic                 clk,
  input  logic                 rstn,
  input  loader_pkg::out_req_t out_req,
  input  logic                 out_valid,
  input  logic                 tx_credit,
  output logic                 out_stall,
  output loader_pkg::byte_t    tx_byte,
  output logic                 tx_valid
);

  localparam int PTR_W = (OUT_DEPTH > 1) ? $clog2(OUT_DEPTH) : 1;
  localparam int CNT_W = $clog2(OUT_DEPTH + 1);
  localparam int CRD_W = $clog2(TX_CREDITS + 1);

  // request queue, oldest at rd_ptr
  loader_pkg::out_req_t queue [OUT_DEPTH];
  logic [PTR_W-1:0]     wr_ptr;
  logic [PTR_W-1:0]     rd_ptr;
  logic [CNT_W-1:0]     fill;
  // free slots in the sink
  logic [CRD_W-1:0]     credits;
  // byte of the head word, 0 is the lsb
  logic [1:0]           byte_idx;
  loader_pkg::out_req_t head;
  loader_pkg::byte_t    head_byte;
  logic                 push;
  logic                 send;
  logic                 last_byte;
  logic                 pop;

  assign out_stall = (fill == CNT_W'(OUT_DEPTH));
  // requests against a full queue are dropped
  assign push      = out_valid && !out_stall;
  assign head      = queue[rd_ptr];
  // one byte per cycle, only with credit
  assign send      = (fill != '0) && (credits != '0);
  // byte mode ends after byte 0
  assign last_byte = head.byte_mode || (byte_idx == 2'd3);
  assign pop       = send && last_byte;
  // every new head starts at index 0, so byte mode picks bits 7:0 here too
  assign head_byte = head.data[8*byte_idx +: 8];

  // queue storage
  always_ff @(posedge clk) begin
    if (push) begin
      queue[wr_ptr] <= out_req;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fill     <= '0;
      byte_idx <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(OUT_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(OUT_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
      // position holds while out of credit
      if (send) begin
        byte_idx <= last_byte ? 2'd0 : byte_idx + 2'd1;
      end
    end
  end

  // credit counter, spent on send, returned by the sink
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      credits  <= CRD_W'(TX_CREDITS);
      tx_valid <= 1'b0;
    end else begin
      tx_valid <= send;
      case ({send, tx_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (send) begin
      tx_byte <= head_byte;
    end
  end

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f src.f --top-module tb_boot_loader -o sim_boot_loader
./obj_dir/sim_boot_loader | tee sim.log

if grep -q "sim failed" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
grep -q "sim passed" sim.log

/* src.f */
+incdir+verif
rtl/loader_pkg.sv
rtl/word_assembler.sv
rtl/loader_ctrl.sv
rtl/word_serializer.sv
rtl/boot_loader_top.sv
verif/tb_boot_loader.sv

/* verif/loader_model.svh */
`ifndef LOADER_MODEL_SVH
`define LOADER_MODEL_SVH

// image words in send order, header first
loader_pkg::word_t    img_words[$];
// writes each memory should see, oldest first
loader_pkg::word_t    exp_dmem[$];
loader_pkg::word_t    exp_imem[$];
// core requests and the tx bytes they turn into
loader_pkg::out_req_t req_q[$];
loader_pkg::byte_t    exp_tx[$];
int unsigned          n_data;
int unsigned          n_prog;
loader_pkg::word_t    exp_pc;

// header: total bytes incl header, data word count, first pc
task automatic build_image();
  loader_pkg::word_t w;
  int unsigned i;
  n_data = (next_rand() >> 16) % 6;
  n_prog = (next_rand() >> 16) % 9;
  exp_pc = next_rand();
  img_words.push_back(loader_pkg::word_t'(4 * (3 + n_data + n_prog)));
  img_words.push_back(loader_pkg::word_t'(n_data));
  img_words.push_back(exp_pc);
  for (i = 0; i < n_data + n_prog; i++) begin
    w = next_rand();
    img_words.push_back(w);
    // data section first, rest is program
    if (i < n_data) begin
      exp_dmem.push_back(w);
    end else begin
      exp_imem.push_back(w);
    end
  end
endtask

// word mode sends four bytes lsb first, byte mode only bits 7:0
task automatic build_requests(input int n);
  loader_pkg::out_req_t req;
  int i;
  int k;
  for (i = 0; i < n; i++) begin
    req.byte_mode = ((next_rand() >> 30) == 0);
    req.data      = next_rand();
    req_q.push_back(req);
    if (req.byte_mode) begin
      exp_tx.push_back(req.data[7:0]);
    end else begin
      for (k = 0; k < 4; k++) begin
        exp_tx.push_back(req.data[8*k +: 8]);
      end
    end
  end
endtask

`endif

/* verif/tb_boot_loader.sv */
`timescale 1ns/1ps

module tb_boot_loader;

  localparam int RX_DEPTH   = 8;
  localparam int OUT_DEPTH  = 16;
  localparam int TX_CREDITS = 4;
  localparam int N_REQ      = 24;
  localparam int N_TESTS    = 5;
  // idle cycles watched once everything is through
  localparam int TAIL       = 16;

  logic                 clk = 1'b0;
  logic                 rstn;
  logic                 enable;
  loader_pkg::byte_t    rx_byte;
  logic                 rx_valid;
  logic                 rx_credit;
  loader_pkg::mem_wr_t  dmem_wr;
  loader_pkg::mem_wr_t  imem_wr;
  loader_pkg::word_t    first_pc;
  loader_pkg::word_t    program_size;
  logic                 program_fin;
  loader_pkg::out_req_t out_req;
  logic                 out_valid;
  logic                 out_stall;
  loader_pkg::byte_t    tx_byte;
  logic                 tx_valid;
  logic                 tx_credit;

  logic [31:0] seed;
  // errors per test: reset, header, data, program, output
  int    err [N_TESTS];
  string test_name [N_TESTS] = '{"reset", "header", "data section",
                                 "program section", "output serialization"};
  // source credits, sink slots, progress counters
  int src_credits;
  int rx_sent;
  int req_sent;
  int sink_free;
  int sink_owed;
  int n_dmem;
  int n_imem;
  bit fin_seen;
  int cycles;
  int limit;
  int tail;
  bit timed_out;
  int total_err;
  int failed;

  always #20 clk = ~clk;

  boot_loader_top #(
    .RX_DEPTH   (RX_DEPTH),
    .OUT_DEPTH  (OUT_DEPTH),
    .TX_CREDITS (TX_CREDITS)
  ) boot_loader_top_i (.*);

  // lcg, numerical recipes constants
  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  `include "loader_model.svh"

  task automatic value_error(input int t, input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    $display("Error %s: got 0x%h, expected 0x%h", name, got, exp);
    err[t]++;
  endtask

  task automatic text_error(input int t, input string msg);
    $display("%s", msg);
    err[t]++;
  endtask

  task automatic check_low(input string name, input logic v);
    if (v !== 1'b0) begin
      text_error(0, $sformatf("%s is not low around reset", name));
    end
  endtask

  task automatic check_reset_outputs();
    check_low("rx_credit", rx_credit);
    check_low("word_valid", boot_loader_top_i.word_valid);
    check_low("dmem_wr.en", dmem_wr.en);
    check_low("imem_wr.en", imem_wr.en);
    check_low("program_fin", program_fin);
    check_low("tx_valid", tx_valid);
    check_low("out_stall", out_stall);
  endtask

  // memory writes in order at 4*i, none after program_fin
  task automatic watch_loader();
    if (dmem_wr.en) begin
      if (fin_seen) begin
        text_error(2, "dmem write after program_fin");
      end
      if (n_dmem >= exp_dmem.size()) begin
        text_error(2, "more dmem writes than data words");
      end else begin
        if (dmem_wr.addr != loader_pkg::word_t'(4 * n_dmem)) begin
          value_error(2, "dmem_wr.addr", dmem_wr.addr, 4 * n_dmem);
        end
        if (dmem_wr.data != exp_dmem[n_dmem]) begin
          value_error(2, "dmem_wr.data", dmem_wr.data, exp_dmem[n_dmem]);
        end
      end
      n_dmem++;
    end
    if (imem_wr.en) begin
      if (fin_seen) begin
        text_error(3, "imem write after program_fin");
      end
      if (n_imem >= exp_imem.size()) begin
        text_error(3, "more imem writes than program words");
      end else begin
        if (imem_wr.addr != loader_pkg::word_t'(4 * n_imem)) begin
          value_error(3, "imem_wr.addr", imem_wr.addr, 4 * n_imem);
        end
        if (imem_wr.data != exp_imem[n_imem]) begin
          value_error(3, "imem_wr.data", imem_wr.data, exp_imem[n_imem]);
        end
      end
      n_imem++;
    end
    if (fin_seen && !program_fin) begin
      text_error(3, "program_fin dropped after it rose");
    end
    if (program_fin) begin
      fin_seen = 1'b1;
    end
  endtask

  // sink side: slot accounting and byte order
  task automatic watch_tx();
    loader_pkg::byte_t exp_b;
    if (tx_valid) begin
      if (sink_free == 0) begin
        text_error(4, "tx_valid while the sink had no free slot");
      end else begin
        sink_free--;
      end
      sink_owed++;
      if (exp_tx.size() == 0) begin
        text_error(4, "tx byte beyond the expected stream");
      end else begin
        exp_b = exp_tx.pop_front();
        if (tx_byte != exp_b) begin
          value_error(4, "tx_byte", 32'(tx_byte), 32'(exp_b));
        end
      end
    end
  endtask

  // byte source, msb of each word first, random gaps
  task automatic drive_source();
    loader_pkg::word_t w;
    rx_valid = 1'b0;
    if (rx_credit) begin
      src_credits++;
    end
    if (src_credits > RX_DEPTH) begin
      text_error(3, "source got back more credits than it started with");
    end
    if (rx_sent < 4 * img_words.size() && src_credits > 0 && (next_rand() >> 31) == 0) begin
      w        = img_words[rx_sent / 4];
      rx_byte  = w[8 * (3 - rx_sent % 4) +: 8];
      rx_valid = 1'b1;
      src_credits--;
      rx_sent++;
    end
    // enable low now and then freezes the fsm
    enable = ((next_rand() >> 30) != 0);
  endtask

  // core only offers a request while out_stall is low
  task automatic drive_core();
    out_valid = 1'b0;
    if (req_sent < req_q.size() && !out_stall && (next_rand() >> 31) == 0) begin
      out_req   = req_q[req_sent];
      out_valid = 1'b1;
      req_sent++;
    end
  endtask

  // slow sink so the output queue backs up
  task automatic drive_sink();
    tx_credit = 1'b0;
    if (sink_owed > 0 && (next_rand() >> 30) == 0) begin
      tx_credit = 1'b1;
      sink_owed--;
      sink_free++;
    end
  endtask

  initial begin
    seed      = 32'h84d1_a1f1;
    rstn      = 1'b0;
    enable    = 1'b0;
    rx_byte   = '0;
    rx_valid  = 1'b0;
    out_req   = '0;
    out_valid = 1'b0;
    tx_credit = 1'b0;
    for (int i = 0; i < N_TESTS; i++) begin
      err[i] = 0;
    end
    src_credits = RX_DEPTH;
    sink_free   = TX_CREDITS;
    build_image();
    build_requests(N_REQ);
    limit = 64 * (4 * img_words.size() + exp_tx.size()) + 200;
    // 4 cycles of reset, then one idle cycle
    repeat (4) begin
      @(negedge clk);
      check_reset_outputs();
    end
    rstn = 1'b1;
    @(negedge clk);
    check_reset_outputs();
    $display("test %s: %0d errors", test_name[0], err[0]);
    while (tail < TAIL && !timed_out) begin
      @(negedge clk);
      cycles++;
      watch_loader();
      watch_tx();
      drive_source();
      drive_core();
      drive_sink();
      if (fin_seen && rx_sent == 4 * img_words.size() && req_sent == req_q.size()
          && exp_tx.size() == 0) begin
        tail++;
      end
      if (cycles >= limit) begin
        timed_out = 1'b1;
        $display("run stopped by the timeout after %0d cycles", cycles);
      end
    end
    if (!fin_seen) begin
      text_error(1, "program_fin never rose");
    end
    if (first_pc != exp_pc) begin
      value_error(1, "first_pc", first_pc, exp_pc);
    end
    if (program_size != loader_pkg::word_t'(n_prog)) begin
      value_error(1, "program_size", program_size, n_prog);
    end
    $display("test %s: %0d errors", test_name[1], err[1]);
    if (n_dmem != n_data) begin
      text_error(2, $sformatf("%0d dmem writes seen, %0d expected", n_dmem, n_data));
    end
    $display("test %s: %0d errors", test_name[2], err[2]);
    if (n_imem != n_prog) begin
      text_error(3, $sformatf("%0d imem writes seen, %0d expected", n_imem, n_prog));
    end
    if (src_credits != RX_DEPTH) begin
      text_error(3, $sformatf("source ends with %0d credits of %0d", src_credits, RX_DEPTH));
    end
    $display("test %s: %0d errors", test_name[3], err[3]);
    if (exp_tx.size() != 0) begin
      text_error(4, $sformatf("%0d expected tx bytes never arrived", exp_tx.size()));
    end
    $display("test %s: %0d errors", test_name[4], err[4]);
    for (int i = 0; i < N_TESTS; i++) begin
      total_err += err[i];
      failed    += (err[i] != 0);
    end
    total_err += timed_out;
    $display("tests %0d, failed %0d, errors %0d, timeouts %0d", N_TESTS, failed, total_err,
             timed_out);
    if (total_err == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
